//--- dv/cam_bist_tb.sv
// Table-driven testbench for the CAM BIST top level, run by the Verilator script with tb.f
`timescale 1ns/1ns
`include "cam_bist_settings.svh"

module cam_bist_tb import cam_bist_pkg::*; ();

  localparam int TIMEOUT    = 2000;
  localparam int N_ROWS     = 20;
  localparam int N_FUNC     = 6;
  // Second start lands in the search pass after the first failures are logged
  localparam int LATE_START = 26;

  // One test case with its expected result
  typedef struct {
    string                   name;
    cam_algo_e               algo;
    logic [`CAM_DWIDTH-1:0]  key;
    logic                    fault_en;
    logic [`CAM_AWIDTH-1:0]  fault_entry;
    logic                    exp_fail;
    logic [`CAM_AWIDTH-1:0]  exp_addr;
  } test_row_t;

  logic                    bist_clk;
  logic                    rst;
  logic                    start;
  cam_bist_cmd_t           cmd;
  cam_fault_t              fault;
  logic                    func_wr;
  logic [`CAM_AWIDTH-1:0]  func_wr_addr;
  logic [`CAM_DWIDTH-1:0]  func_wr_data;
  logic                    func_rd;
  logic [`CAM_AWIDTH-1:0]  func_rd_addr;
  cam_bist_status_t        status;
  logic                    busy;
  logic [`CAM_DWIDTH-1:0]  rd_data;
  logic                    rd_valid;

  test_row_t               rows [N_ROWS];
  int                      n_rows;

  cam_bist_top u_dut (
    .bist_clk, .rst, .start, .cmd, .fault, .func_wr, .func_wr_addr, .func_wr_data,
    .func_rd, .func_rd_addr, .status, .busy, .rd_data, .rd_valid
  );

  // 20 ns clock
  always #10 bist_clk = ~bist_clk;

  // ============================================================
  // Failure handling and compare tasks
  // ============================================================
  task automatic abort_run(input string why);
    $display("CHECKS FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_status(input string name, input logic exp_fail,
                              input cam_algo_e exp_algo,
                              input logic [`CAM_AWIDTH-1:0] exp_addr,
                              input cam_bist_status_t act);
    logic bad;
    bad = (act.fail !== exp_fail);
    // Algorithm and address only mean something on a failing run
    if (exp_fail) begin
      bad = bad || (act.fail_algo !== exp_algo) || (act.fail_addr !== exp_addr);
    end
    if (bad) begin
      $display("** Error %s: expected fail=%0b algo=%s addr=%0d, actual fail=%0b algo=%s addr=%0d",
               name, exp_fail, exp_algo.name(), exp_addr,
               act.fail, act.fail_algo.name(), act.fail_addr);
      abort_run("status mismatch");
    end
  endtask

  task automatic check_data(input string name, input logic [`CAM_DWIDTH-1:0] exp,
                            input logic [`CAM_DWIDTH-1:0] act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      abort_run("read data mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      abort_run("flag mismatch");
    end
  endtask

  // ============================================================
  // Stimulus helpers
  // ============================================================
  task automatic add_row(input string name, input cam_algo_e algo,
                         input logic [`CAM_DWIDTH-1:0] key, input logic fen,
                         input logic [`CAM_AWIDTH-1:0] fentry, input logic exp_fail,
                         input logic [`CAM_AWIDTH-1:0] exp_addr);
    rows[n_rows] = '{name, algo, key, fen, fentry, exp_fail, exp_addr};
    n_rows++;
  endtask

  // Starts one BIST run and repeats the start late in the run before waiting for done
  task automatic run_row(input int idx);
    int cycles;
    fault.en     = rows[idx].fault_en;
    fault.entry  = rows[idx].fault_entry;
    cmd.algo     = rows[idx].algo;
    cmd.key      = rows[idx].key;
    start        = 1'b1;
    @(negedge bist_clk);
    start = 1'b0;
    check_bit({rows[idx].name, " busy after start"}, 1'b1, busy);
    for (int c = 0; c < LATE_START; c++) begin
      @(negedge bist_clk);
      check_bit({rows[idx].name, " busy before second start"}, 1'b1, busy);
    end
    // A different command that must be dropped while busy
    cmd.algo = cam_algo_e'(~rows[idx].algo);
    cmd.key  = ~rows[idx].key;
    start    = 1'b1;
    @(negedge bist_clk);
    start  = 1'b0;
    cycles = 0;
    while (!status.done) begin
      check_bit({rows[idx].name, " busy during run"}, 1'b1, busy);
      if (cycles >= TIMEOUT) begin
        abort_run({"timeout waiting for status.done in ", rows[idx].name});
      end
      @(negedge bist_clk);
      cycles++;
    end
    check_bit({rows[idx].name, " busy at done"}, 1'b0, busy);
    check_status(rows[idx].name, rows[idx].exp_fail, rows[idx].algo,
                 rows[idx].exp_addr, status);
    @(negedge bist_clk);
    check_bit({rows[idx].name, " done one cycle"}, 1'b0, status.done);
  endtask

  task automatic func_write(input logic [`CAM_AWIDTH-1:0] addr,
                            input logic [`CAM_DWIDTH-1:0] data);
    func_wr      = 1'b1;
    func_wr_addr = addr;
    func_wr_data = data;
    @(negedge bist_clk);
    func_wr = 1'b0;
  endtask

  // Read data must show up exactly two cycles after the strobe
  task automatic func_read_check(input string name, input logic [`CAM_AWIDTH-1:0] addr,
                                 input logic [`CAM_DWIDTH-1:0] exp);
    func_rd      = 1'b1;
    func_rd_addr = addr;
    @(negedge bist_clk);
    func_rd = 1'b0;
    check_bit({name, " rd_valid early"}, 1'b0, rd_valid);
    @(negedge bist_clk);
    check_bit({name, " rd_valid"}, 1'b1, rd_valid);
    check_data(name, exp, rd_data);
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin : main
    logic [`CAM_DWIDTH-1:0]  wdata [N_FUNC];
    logic [`CAM_AWIDTH-1:0]  faddr;

    void'($urandom(32'hf6dc794a));
    bist_clk     = 1'b0;
    rst          = 1'b1;
    start        = 1'b0;
    cmd          = '0;
    fault        = '0;
    func_wr      = 1'b0;
    func_wr_addr = '0;
    func_wr_data = '0;
    func_rd      = 1'b0;
    func_rd_addr = '0;
    n_rows       = 0;

    // Fault-free runs with two keys
    add_row("am_5a",     ALGO_ALL_MATCH,       `CAM_BIST_KEY, 1'b0, 4'd0,  1'b0, 4'd0);
    add_row("sm_5a",     ALGO_SINGLE_MATCH,    `CAM_BIST_KEY, 1'b0, 4'd0,  1'b0, 4'd0);
    add_row("smm_5a",    ALGO_SINGLE_MISMATCH, `CAM_BIST_KEY, 1'b0, 4'd0,  1'b0, 4'd0);
    add_row("amm_5a",    ALGO_ALL_MISMATCH,    `CAM_BIST_KEY, 1'b0, 4'd0,  1'b0, 4'd0);
    add_row("am_c3",     ALGO_ALL_MATCH,       8'hC3,         1'b0, 4'd0,  1'b0, 4'd0);
    add_row("sm_c3",     ALGO_SINGLE_MATCH,    8'hC3,         1'b0, 4'd0,  1'b0, 4'd0);
    add_row("smm_c3",    ALGO_SINGLE_MISMATCH, 8'hC3,         1'b0, 4'd0,  1'b0, 4'd0);
    add_row("amm_c3",    ALGO_ALL_MISMATCH,    8'hC3,         1'b0, 4'd0,  1'b0, 4'd0);
    // Stuck-at-0 on match line 0 where the mismatch pass trips first at entry 1
    add_row("am_f0",     ALGO_ALL_MATCH,       `CAM_BIST_KEY, 1'b1, 4'd0,  1'b1, 4'd0);
    add_row("sm_f0",     ALGO_SINGLE_MATCH,    `CAM_BIST_KEY, 1'b1, 4'd0,  1'b1, 4'd0);
    add_row("smm_f0",    ALGO_SINGLE_MISMATCH, `CAM_BIST_KEY, 1'b1, 4'd0,  1'b1, 4'd1);
    add_row("amm_f0",    ALGO_ALL_MISMATCH,    `CAM_BIST_KEY, 1'b1, 4'd0,  1'b0, 4'd0);
    // Line 5
    add_row("am_f5",     ALGO_ALL_MATCH,       8'hC3,         1'b1, 4'd5,  1'b1, 4'd0);
    add_row("sm_f5",     ALGO_SINGLE_MATCH,    8'hC3,         1'b1, 4'd5,  1'b1, 4'd5);
    add_row("smm_f5",    ALGO_SINGLE_MISMATCH, 8'hC3,         1'b1, 4'd5,  1'b1, 4'd0);
    add_row("amm_f5",    ALGO_ALL_MISMATCH,    8'hC3,         1'b1, 4'd5,  1'b0, 4'd0);
    // Last line
    add_row("am_f15",    ALGO_ALL_MATCH,       `CAM_BIST_KEY, 1'b1, 4'd15, 1'b1, 4'd0);
    add_row("sm_f15",    ALGO_SINGLE_MATCH,    `CAM_BIST_KEY, 1'b1, 4'd15, 1'b1, 4'd15);
    add_row("smm_f15",   ALGO_SINGLE_MISMATCH, `CAM_BIST_KEY, 1'b1, 4'd15, 1'b1, 4'd0);
    add_row("amm_f15",   ALGO_ALL_MISMATCH,    `CAM_BIST_KEY, 1'b1, 4'd15, 1'b0, 4'd0);

    // Four cycles of reset
    repeat (4) @(negedge bist_clk);
    rst = 1'b0;
    @(negedge bist_clk);
    check_bit("reset busy", 1'b0, busy);
    check_bit("reset rd_valid", 1'b0, rd_valid);
    check_bit("reset fail", 1'b0, status.fail);
    check_bit("reset done", 1'b0, status.done);

    for (int t = 0; t < n_rows; t++) begin
      run_row(t);
    end

    // Functional path after the last run with the fault left in place
    for (int k = 0; k < N_FUNC; k++) begin
      faddr    = `CAM_AWIDTH'(k * 3);
      wdata[k] = `CAM_DWIDTH'($urandom);
      func_write(faddr, wdata[k]);
    end
    for (int k = 0; k < N_FUNC; k++) begin
      faddr = `CAM_AWIDTH'(k * 3);
      func_read_check($sformatf("func_rd_%0d", faddr), faddr, wdata[k]);
    end
    @(negedge bist_clk);
    check_bit("rd_valid after reads", 1'b0, rd_valid);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the CAM BIST testbench with Verilator and runs it.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module cam_bist_tb -o cam_bist_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/cam_bist_sim; then
  echo "Simulation failed"
  exit 1
fi

exit 0

//--- tb.f
+incdir+verilog
verilog/cam_bist_pkg.sv
verilog/cam_bist_ctrl.sv
verilog/cam_bist_addr_cnt.sv
verilog/cam_array.sv
verilog/cam_bist_outhandler.sv
verilog/cam_bist_fail_log.sv
verilog/cam_bist_top.sv
dv/cam_bist_tb.sv

//--- verilog/cam_array.sv
// Behavioural binary CAM model with write, pipelined search and read, and a match line defect
`timescale 1ns/1ns
`include "cam_bist_settings.svh"

module cam_array import cam_bist_pkg::*; #(
  parameter int ENTRIES = `CAM_ENTRIES,
  parameter int DWIDTH  = `CAM_DWIDTH,
  localparam int AW     = $clog2(ENTRIES)
) (
  input  logic               bist_clk,
  input  logic               rst,
  input  logic               wr_en,
  input  logic [AW-1:0]      wr_addr,
  input  logic [DWIDTH-1:0]  wr_data,
  input  cam_search_t        search,
  input  logic               rd_en,
  input  logic [AW-1:0]      rd_addr,
  input  cam_fault_t         fault,
  output logic [ENTRIES-1:0] match_lines,
  output logic [DWIDTH-1:0]  rd_data,
  output logic               rd_valid
);

  logic [DWIDTH-1:0]  mem [ENTRIES];
  logic [DWIDTH-1:0]  key_q;
  logic [ENTRIES-1:0] match_d;
  logic               rd_en_q;
  logic [AW-1:0]      rd_addr_q;

  // Storage
  always_ff @(posedge bist_clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
  end

  // ============================================================
  // Search, stage 1 key register, stage 2 match register
  // ============================================================
  always_ff @(posedge bist_clk) begin
    if (search.valid) key_q <= search.key;
  end

  // Compare against every entry, defect pulls its line low
  always_comb begin
    for (int i = 0; i < ENTRIES; i++) begin
      match_d[i] = (mem[i] == key_q) && !(fault.en && (int'(fault.entry) == i));
    end
  end

  always_ff @(posedge bist_clk) begin
    match_lines <= match_d;
  end

  // ============================================================
  // Read, same two stage latency as search
  // ============================================================
  always_ff @(posedge bist_clk) begin
    if (rst) begin
      rd_en_q  <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      rd_en_q  <= rd_en;
      rd_valid <= rd_en_q;
    end
  end

  always_ff @(posedge bist_clk) begin
    if (rd_en) rd_addr_q <= rd_addr;
    if (rd_en_q) rd_data <= mem[rd_addr_q];
  end

endmodule

//--- verilog/cam_bist_addr_cnt.sv
// Entry address counter and result drain timer, stepped by the BIST controller
`timescale 1ns/1ns
`include "cam_bist_settings.svh"

module cam_bist_addr_cnt (
  input  logic                    bist_clk,
  input  logic                    rst,
  input  logic                    clear,
  input  logic                    step,
  input  logic                    drain_load,
  output logic [`CAM_AWIDTH-1:0]  addr,
  output logic                    last,
  output logic                    drain_done
);

  // Wide enough for the drain load value
  localparam int DW = $clog2(`CAM_SRCH_LAT + 2);

  logic [DW-1:0] drain_cnt;

  assign last       = (addr == `CAM_AWIDTH'(`CAM_ENTRIES - 1));
  assign drain_done = (drain_cnt == DW'(1));

  // ============================================================
  // Entry address, wraps after the last entry
  // ============================================================
  always_ff @(posedge bist_clk) begin
    if (rst || clear) begin
      addr <= '0;
    end else if (step) begin
      addr <= last ? '0 : addr + 1'b1;
    end
  end

  // Drain countdown, ends with drain_done on its last cycle
  always_ff @(posedge bist_clk) begin
    if (rst) begin
      drain_cnt <= '0;
    end else if (drain_load) begin
      drain_cnt <= DW'(`CAM_SRCH_LAT + 1);
    end else if (drain_cnt != '0) begin
      drain_cnt <= drain_cnt - 1'b1;
    end
  end

  a_step_clear_excl: assert property (@(posedge bist_clk) disable iff (rst)
    !(step && clear));

endmodule

//--- verilog/cam_bist_ctrl.sv
// Test controller FSM that fills the CAM and issues one search per entry for the chosen algorithm
`timescale 1ns/1ns
`include "cam_bist_settings.svh"

module cam_bist_ctrl import cam_bist_pkg::*; (
  input  logic                    bist_clk,
  input  logic                    rst,
  input  logic                    start,
  input  cam_bist_cmd_t           cmd,
  input  logic [`CAM_AWIDTH-1:0]  addr,
  input  logic                    last,
  input  logic                    drain_done,
  output logic                    busy,
  output logic                    cnt_clear,
  output logic                    cnt_step,
  output logic                    drain_load,
  output logic                    wr_en,
  output logic [`CAM_AWIDTH-1:0]  wr_addr,
  output logic [`CAM_DWIDTH-1:0]  wr_data,
  output cam_search_t             search,
  output cam_algo_e               algo,
  output logic                    done
);

  cam_state_e              state_q;
  cam_state_e              state_d;
  logic [`CAM_DWIDTH-1:0]  key_q;
  logic [`CAM_DWIDTH-1:0]  addr_key;

  // Entry index widened to key width, used as the single match pattern
  assign addr_key = {{(`CAM_DWIDTH-`CAM_AWIDTH){1'b0}}, addr};
  assign busy     = (state_q != IDLE);

  // ============================================================
  // State and command latch
  // ============================================================
  always_ff @(posedge bist_clk) begin
    if (rst) begin
      state_q <= IDLE;
      algo    <= ALGO_ALL_MATCH;
    end else begin
      state_q <= state_d;
      // Command accepted only when idle
      if (state_q == IDLE && start) algo <= cmd.algo;
    end
  end

  always_ff @(posedge bist_clk) begin
    if (state_q == IDLE && start) key_q <= cmd.key;
  end

  // ============================================================
  // Next state and strobes
  // ============================================================
  always_comb begin
    state_d    = state_q;
    cnt_clear  = 1'b0;
    cnt_step   = 1'b0;
    drain_load = 1'b0;
    wr_en      = 1'b0;
    wr_addr    = addr;
    wr_data    = key_q;
    search     = '0;
    done       = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (start) begin
          cnt_clear = 1'b1;
          state_d   = FILL;
        end
      end
      FILL: begin
        // Single match gets a distinct pattern per entry
        wr_en    = 1'b1;
        wr_data  = (algo == ALGO_SINGLE_MATCH) ? (key_q ^ addr_key) : key_q;
        cnt_step = 1'b1;
        if (last) state_d = (algo == ALGO_SINGLE_MISMATCH) ? SEARCH_SETUP : SEARCH;
      end
      SEARCH_SETUP: begin
        // Corrupt entry under test so that only it mismatches
        wr_en   = 1'b1;
        wr_data = ~key_q;
        state_d = SEARCH;
      end
      SEARCH: begin
        search.valid = 1'b1;
        search.bist  = 1'b1;
        search.addr  = addr;
        unique case (algo)
          ALGO_ALL_MATCH:       search.key = key_q;
          ALGO_SINGLE_MATCH:    search.key = key_q ^ addr_key;
          ALGO_SINGLE_MISMATCH: search.key = key_q;
          ALGO_ALL_MISMATCH:    search.key = ~key_q;
          default:              search.key = key_q;
        endcase
        if (algo == ALGO_SINGLE_MISMATCH) begin
          state_d = RESTORE;
        end else begin
          cnt_step = 1'b1;
          if (last) begin
            drain_load = 1'b1;
            state_d    = DRAIN;
          end
        end
      end
      RESTORE: begin
        wr_en    = 1'b1;
        cnt_step = 1'b1;
        if (last) begin
          drain_load = 1'b1;
          state_d    = DRAIN;
        end else begin
          state_d = SEARCH_SETUP;
        end
      end
      // Wait for the last results to reach the fail logger
      DRAIN:   if (drain_done) state_d = DONE;
      DONE: begin
        done    = 1'b1;
        state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  // Array port cannot serve a write and a search in one cycle
  a_no_wr_and_search: assert property (@(posedge bist_clk) disable iff (rst)
    !(search.valid && wr_en));

  // A start during a run is dropped
  a_start_busy_ignored: assert property (@(posedge bist_clk) disable iff (rst)
    (start && busy) |=> $stable(algo));

endmodule

//--- verilog/cam_bist_fail_log.sv
// Fail logger that checks each compacted search result and keeps the first failing algorithm and address
`timescale 1ns/1ns
`include "cam_bist_settings.svh"

module cam_bist_fail_log import cam_bist_pkg::*; (
  input  logic                    bist_clk,
  input  logic                    rst,
  input  logic                    start,
  input  logic                    search_valid,
  input  cam_algo_e               algo,
  input  logic [`CAM_AWIDTH-1:0]  search_addr,
  input  logic [`CAM_DWIDTH-1:0]  cmp_data,
  input  logic                    done_in,
  output cam_bist_status_t        status
);

  localparam int LAT = `CAM_SRCH_LAT;

  logic [LAT-1:0]          vld_sr;
  logic [`CAM_AWIDTH-1:0]  addr_sr [LAT];

  // ============================================================
  // Delay strobe and address to the result cycle
  // ============================================================
  always_ff @(posedge bist_clk) begin
    if (rst) vld_sr <= '0;
    else     vld_sr <= {vld_sr[LAT-2:0], search_valid};
  end

  always_ff @(posedge bist_clk) begin
    addr_sr[0] <= search_addr;
    for (int i = 1; i < LAT; i++) begin
      addr_sr[i] <= addr_sr[i-1];
    end
  end

  // Result capture, held until the next start
  always_ff @(posedge bist_clk) begin
    if (rst) begin
      status <= '0;
    end else begin
      status.done <= done_in;
      if (start) begin
        status.fail      <= 1'b0;
        status.fail_algo <= ALGO_ALL_MATCH;
        status.fail_addr <= '0;
      end else if (vld_sr[LAT-1] && (cmp_data != '0)) begin
        status.fail <= 1'b1;
        // Only the first failure is recorded
        if (!status.fail) begin
          status.fail_algo <= algo;
          status.fail_addr <= addr_sr[LAT-1];
        end
      end
    end
  end

endmodule

//--- verilog/cam_bist_outhandler.sv
// Builds expected match lines, compares and compacts them, and muxes the result onto read data
`timescale 1ns/1ns

module cam_bist_outhandler import cam_bist_pkg::*; #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH  = 8,
  parameter int AWIDTH  = 4
) (
  input  logic               bist_clk,
  input  cam_search_t        search,
  input  cam_algo_e          algo,
  input  logic [ENTRIES-1:0] match_lines,
  input  logic [DWIDTH-1:0]  rd_data_in,
  output logic [DWIDTH-1:0]  rd_data_out,
  output logic [ENTRIES-1:0] match_ref
);

  localparam int MULT = ENTRIES / DWIDTH;
  localparam int REM  = ENTRIES % DWIDTH;

  logic [AWIDTH-1:0]  addr_d1;
  logic [AWIDTH-1:0]  addr_d2;
  logic               bist_d1;
  logic               bist_d2;
  logic [ENTRIES-1:0] one_hot;
  logic [ENTRIES-1:0] diff;
  logic [DWIDTH-1:0]  cmp_data;

  // ============================================================
  // Align search address and mode with the match lines
  // ============================================================
  always_ff @(posedge bist_clk) begin
    addr_d1 <= search.addr;
    addr_d2 <= addr_d1;
    bist_d1 <= search.bist;
    bist_d2 <= bist_d1;
  end

  assign one_hot = {{(ENTRIES-1){1'b0}}, 1'b1} << addr_d2;

  // Expected vector per algorithm
  always_comb begin
    unique case (algo)
      ALGO_ALL_MATCH:       match_ref = '1;
      ALGO_SINGLE_MATCH:    match_ref = one_hot;
      ALGO_SINGLE_MISMATCH: match_ref = ~one_hot;
      ALGO_ALL_MISMATCH:    match_ref = '0;
      default:              match_ref = '0;
    endcase
  end

  // Any set bit is a failing match line
  assign diff = match_ref ^ match_lines;

  // ============================================================
  // Fit the difference onto the data bus
  // ============================================================
  if (ENTRIES > DWIDTH) begin : g_compact
    logic [DWIDTH-1:0] fold;
    always_comb begin
      fold = '0;
      for (int m = 0; m < MULT; m++) begin
        fold = fold | diff[m*DWIDTH +: DWIDTH];
      end
    end
    // Leftover lines beyond the last full slice
    if (REM != 0) begin : g_rem
      assign cmp_data = fold | {{(DWIDTH-REM){1'b0}}, diff[ENTRIES-1:MULT*DWIDTH]};
    end else begin : g_no_rem
      assign cmp_data = fold;
    end
  end else if (ENTRIES == DWIDTH) begin : g_equal
    assign cmp_data = diff;
  end else begin : g_expand
    assign cmp_data = {{(DWIDTH-ENTRIES){1'b0}}, diff};
  end

  // Test result on search cycles, functional data otherwise
  assign rd_data_out = bist_d2 ? cmp_data : rd_data_in;

endmodule

//--- verilog/cam_bist_pkg.sv
// Shared enums and packed structs for the CAM BIST, imported by every RTL module and the testbench
`include "cam_bist_settings.svh"

package cam_bist_pkg;

  // Algorithm opcode, same encoding as the match select pair
  typedef enum logic [1:0] {
    ALGO_ALL_MATCH       = 2'b00,
    ALGO_SINGLE_MATCH    = 2'b01,
    ALGO_SINGLE_MISMATCH = 2'b10,
    ALGO_ALL_MISMATCH    = 2'b11
  } cam_algo_e;

  // Test controller states
  typedef enum logic [2:0] {
    IDLE,
    FILL,
    SEARCH_SETUP,
    SEARCH,
    RESTORE,
    DRAIN,
    DONE
  } cam_state_e;

  // Start command, valid with the start strobe
  typedef struct packed {
    cam_algo_e               algo;
    logic [`CAM_DWIDTH-1:0]  key;
  } cam_bist_cmd_t;

  // One search request
  typedef struct packed {
    logic                    valid;
    logic [`CAM_DWIDTH-1:0]  key;
    logic [`CAM_AWIDTH-1:0]  addr;   // entry the expected vector is built for
    logic                    bist;   // test mode, selects compare data on read bus
  } cam_search_t;

  // Test result
  typedef struct packed {
    logic                    done;
    logic                    fail;
    cam_algo_e               fail_algo;
    logic [`CAM_AWIDTH-1:0]  fail_addr;
  } cam_bist_status_t;

  // Stuck-at-0 defect on one match line
  typedef struct packed {
    logic                    en;
    logic [`CAM_AWIDTH-1:0]  entry;
  } cam_fault_t;

endpackage

//--- verilog/cam_bist_settings.svh
// Geometry, pipeline depth and default key for the CAM BIST, included by package, RTL and testbench
`ifndef CAM_BIST_SETTINGS_SVH
`define CAM_BIST_SETTINGS_SVH

// ============================================================
// Array geometry
// ============================================================

// Number of CAM entries, one match line each
`define CAM_ENTRIES 16

// Key width, also the read-data width
`define CAM_DWIDTH 8

// Entry address width
`define CAM_AWIDTH 4

// ============================================================
// Timing and test defaults
// ============================================================

// Cycles from search or read strobe to result
`define CAM_SRCH_LAT 2

// Key pattern used when no other key is given
`define CAM_BIST_KEY 8'h5A

`endif

//--- verilog/cam_bist_top.sv
// CAM BIST top level, connects controller, counter, array, output handler and fail logger
`timescale 1ns/1ns
`include "cam_bist_settings.svh"

module cam_bist_top import cam_bist_pkg::*; (
  input  logic                    bist_clk,
  input  logic                    rst,
  input  logic                    start,
  input  cam_bist_cmd_t           cmd,
  input  cam_fault_t              fault,
  input  logic                    func_wr,
  input  logic [`CAM_AWIDTH-1:0]  func_wr_addr,
  input  logic [`CAM_DWIDTH-1:0]  func_wr_data,
  input  logic                    func_rd,
  input  logic [`CAM_AWIDTH-1:0]  func_rd_addr,
  output cam_bist_status_t        status,
  output logic                    busy,
  output logic [`CAM_DWIDTH-1:0]  rd_data,
  output logic                    rd_valid
);

  logic                    cnt_clear, cnt_step, drain_load, drain_done, last, done;
  logic [`CAM_AWIDTH-1:0]  addr;
  logic                    ctrl_wr_en, arr_wr_en, arr_rd_en, start_ok;
  logic [`CAM_AWIDTH-1:0]  ctrl_wr_addr, arr_wr_addr;
  logic [`CAM_DWIDTH-1:0]  ctrl_wr_data, arr_wr_data, arr_rd_data;
  logic [`CAM_ENTRIES-1:0] match_lines;
  cam_search_t             search;
  cam_algo_e               algo;

  // ============================================================
  // Array port owner, BIST while busy, functional otherwise
  // ============================================================
  assign arr_wr_en   = busy ? ctrl_wr_en   : func_wr;
  assign arr_wr_addr = busy ? ctrl_wr_addr : func_wr_addr;
  assign arr_wr_data = busy ? ctrl_wr_data : func_wr_data;
  assign arr_rd_en   = func_rd && !busy;
  // A start during a run must not clear the logged result
  assign start_ok    = start && !busy;

  cam_bist_ctrl u_ctrl (
    .bist_clk, .rst, .start, .cmd, .addr, .last, .drain_done, .busy, .cnt_clear, .cnt_step,
    .drain_load, .wr_en(ctrl_wr_en), .wr_addr(ctrl_wr_addr), .wr_data(ctrl_wr_data),
    .search, .algo, .done
  );

  cam_bist_addr_cnt u_cnt (
    .bist_clk, .rst, .clear(cnt_clear), .step(cnt_step), .drain_load, .addr, .last, .drain_done
  );

  cam_array #(.ENTRIES(`CAM_ENTRIES), .DWIDTH(`CAM_DWIDTH)) u_array (
    .bist_clk, .rst, .wr_en(arr_wr_en), .wr_addr(arr_wr_addr), .wr_data(arr_wr_data), .search,
    .rd_en(arr_rd_en), .rd_addr(func_rd_addr), .fault, .match_lines, .rd_data(arr_rd_data),
    .rd_valid
  );

  cam_bist_outhandler #(
    .ENTRIES(`CAM_ENTRIES), .DWIDTH(`CAM_DWIDTH), .AWIDTH(`CAM_AWIDTH)
  ) u_outhandler (
    .bist_clk, .search, .algo, .match_lines, .rd_data_in(arr_rd_data), .rd_data_out(rd_data),
    .match_ref()
  );

  cam_bist_fail_log u_fail_log (
    .bist_clk, .rst, .start(start_ok), .search_valid(search.valid), .algo,
    .search_addr(search.addr), .cmp_data(rd_data), .done_in(done), .status
  );

endmodule
